// File: compile.f
+incdir+logic
logic/align_pkg.sv
logic/matrix_ram.sv
logic/align_regs.sv
logic/align_ctrl.sv
logic/fill_engine.sv
logic/traceback.sv
logic/align_top.sv
bench/align_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module align_tb -f compile.f -o Valign_tb

./obj_dir/Valign_tb | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: bench/align_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "align_consts.svh"

module align_tb;

    localparam integer RUNS         = 20;
    localparam integer INIT_CYCLES  = 2 * `SEQ_LEN + 1;
    localparam integer FILL_CYCLES  = (`SEQ_LEN * `SEQ_LEN / `GROUP) * 11;
    localparam integer TRACE_CYCLES = 2 * (2 * `SEQ_LEN);
    localparam integer CFG_CYCLES   = 2 * (2 * `SEQ_LEN + 6);  // setup plus writes while busy
    localparam integer RUN_CYCLES   = INIT_CYCLES + FILL_CYCLES + TRACE_CYCLES + CFG_CYCLES;
    localparam integer CYCLE_LIMIT  = (RUNS + 1) * RUN_CYCLES + 100;

    logic                   clk;
    logic                   rst;
    logic                   cfg_we;
    logic [`CFG_ADDR_W-1:0] cfg_addr;
    logic [7:0]             cfg_wdata;
    align_pkg::op_t         op;
    logic                   op_valid;
    align_pkg::score_t      score;
    logic                   done;
    logic                   busy;

    integer seed;
    integer errors;
    integer cycles;
    integer done_score;
    logic   armed;                            // a start was written and done is still pending
    logic   run_done;

    logic [1:0] seq_a_v [0:`SEQ_LEN-1];
    logic [1:0] seq_b_v [0:`SEQ_LEN-1];
    integer     match_v;
    integer     mismatch_v;
    integer     gap_v;

    integer          ref_score [0:`SEQ_LEN][0:`SEQ_LEN];
    align_pkg::dir_t ref_dir   [0:`SEQ_LEN][0:`SEQ_LEN];
    align_pkg::op_t  exp_ops [$];
    align_pkg::op_t  got_ops [$];

    align_top UUT (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .op(op), .op_valid(op_valid), .score(score), .done(done), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input integer got, input integer expected, input string what);
        begin
            if (got !== expected) begin
                errors = errors + 1;
                $display("** Error at time %0t: %s, got %0d, expected %0d",
                         $time, what, got, expected);
                $display("Done: errors found");
                $fatal(1, "stopped at the first mismatch");
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // reference alignment

    task automatic fill_reference;
        integer i;
        integer j;
        integer dg;
        integer up;
        integer lf;
        begin
            for (j = 0; j <= `SEQ_LEN; j = j + 1) begin
                ref_score[0][j] = j * gap_v;
                ref_dir[0][j]   = align_pkg::DIR_LEFT;
            end
            for (i = 1; i <= `SEQ_LEN; i = i + 1) begin
                ref_score[i][0] = i * gap_v;
                ref_dir[i][0]   = align_pkg::DIR_UP;
            end
            ref_dir[0][0] = align_pkg::DIR_NONE;
            for (i = 1; i <= `SEQ_LEN; i = i + 1) begin
                for (j = 1; j <= `SEQ_LEN; j = j + 1) begin
                    dg = ref_score[i-1][j-1] +
                         ((seq_a_v[i-1] == seq_b_v[j-1]) ? match_v : mismatch_v);
                    up = ref_score[i-1][j] + gap_v;
                    lf = ref_score[i][j-1] + gap_v;
                    if (dg >= up && dg >= lf) begin     // diagonal wins every tie
                        ref_score[i][j] = dg;
                        ref_dir[i][j]   = align_pkg::DIR_DIAG;
                    end else if (up >= lf) begin
                        ref_score[i][j] = up;
                        ref_dir[i][j]   = align_pkg::DIR_UP;
                    end else begin
                        ref_score[i][j] = lf;
                        ref_dir[i][j]   = align_pkg::DIR_LEFT;
                    end
                end
            end
        end
    endtask

    task automatic trace_reference;
        integer i;
        integer j;
        begin
            exp_ops.delete();
            i = `SEQ_LEN;
            j = `SEQ_LEN;
            while (i > 0 || j > 0) begin
                if (ref_dir[i][j] == align_pkg::DIR_DIAG) begin
                    if (seq_a_v[i-1] == seq_b_v[j-1]) begin
                        exp_ops.push_back(align_pkg::OP_MATCH);
                    end else begin
                        exp_ops.push_back(align_pkg::OP_SUB);
                    end
                    i = i - 1;
                    j = j - 1;
                end else if (ref_dir[i][j] == align_pkg::DIR_UP) begin
                    exp_ops.push_back(align_pkg::OP_DEL);
                    i = i - 1;
                end else begin
                    exp_ops.push_back(align_pkg::OP_INS);
                    j = j - 1;
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // register writes, driven on the falling edge

    task automatic write_reg(input integer addr, input integer data);
        begin
            @(negedge clk);
            cfg_we    = 1'b1;
            cfg_addr  = addr[`CFG_ADDR_W-1:0];
            cfg_wdata = data[7:0];
        end
    endtask

    task automatic release_bus;
        begin
            @(negedge clk);
            cfg_we = 1'b0;
        end
    endtask

    task automatic draw_config;
        integer k;
        begin
            for (k = 0; k < `SEQ_LEN; k = k + 1) begin
                seq_a_v[k] = $random(seed) & 3;
                seq_b_v[k] = $random(seed) & 3;
            end
            match_v    = $unsigned($random(seed)) % 4;
            mismatch_v = -($unsigned($random(seed)) % 4);
            gap_v      = -1 - ($unsigned($random(seed)) % 3);
        end
    endtask

    task automatic run_alignment(input logic write_while_busy);
        integer k;
        begin
            fill_reference();
            trace_reference();
            for (k = 0; k < `SEQ_LEN; k = k + 1) begin
                write_reg(`REG_SEQ_A + k, seq_a_v[k]);
                write_reg(`REG_SEQ_B + k, seq_b_v[k]);
            end
            write_reg(`REG_MATCH, match_v);
            write_reg(`REG_MISMATCH, mismatch_v);
            write_reg(`REG_GAP, gap_v);
            got_ops.delete();
            run_done = 1'b0;
            armed    = 1'b1;
            write_reg(`REG_START, 0);
            release_bus();
            check_value(busy, 1, "busy after start write");
            if (write_while_busy) begin
                for (k = 0; k <= `REG_START; k = k + 1) begin
                    write_reg(k, $random(seed));            // all of these must be ignored
                end
                release_bus();
            end
            while (!run_done) @(posedge clk);
            check_value(done_score, ref_score[`SEQ_LEN][`SEQ_LEN], "final score");
            check_value(got_ops.size(), exp_ops.size(), "op count");
            for (k = 0; k < exp_ops.size(); k = k + 1) begin
                check_value(int'(got_ops[k]), int'(exp_ops[k]), $sformatf("op %0d", k));
            end
            @(negedge clk);
            check_value(busy, 0, "busy after done");
        end
    endtask

    // op and done are sampled mid-cycle where they are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (op_valid) begin
                check_value(armed, 1, "op_valid outside a run");
                got_ops.push_back(op);
            end
            if (done) begin
                check_value(armed, 1, "done outside a run");
                done_score = score;
                armed      = 1'b0;
                run_done   = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $fatal(1, "stopped on a timeout");
        end
    end

    initial begin
        integer r;
        integer k;
        seed      = 32'h81f2_10ad;
        errors    = 0;
        cycles    = 0;
        armed     = 1'b0;
        run_done  = 1'b0;
        rst       = 1'b1;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value(busy, 0, "busy after reset");
        check_value(done, 0, "done after reset");
        check_value(op_valid, 0, "op_valid after reset");
        repeat (4) @(negedge clk);

        for (r = 0; r < RUNS; r = r + 1) begin
            draw_config();
            run_alignment(r[0]);                        // odd runs also scribble while busy
        end

        draw_config();
        for (k = 0; k < `SEQ_LEN; k = k + 1) begin
            seq_b_v[k] = seq_a_v[k];
        end
        match_v = 1 + $unsigned($random(seed)) % 3;
        run_alignment(1'b0);
        check_value(done_score, `SEQ_LEN * match_v, "score of identical sequences");
        check_value(got_ops.size(), `SEQ_LEN, "op count of identical sequences");
        for (k = 0; k < got_ops.size(); k = k + 1) begin
            check_value(int'(got_ops[k]), int'(align_pkg::OP_MATCH),
                        $sformatf("identical sequences op %0d", k));
        end

        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/align_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "align_consts.svh"

module align_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cfg_we,
    input  wire logic [`CFG_ADDR_W-1:0] cfg_addr,
    input  wire logic [7:0]             cfg_wdata,
    output align_pkg::op_t              op,
    output logic                        op_valid,
    output align_pkg::score_t           score,
    output logic                        done,
    output logic                        busy
);

    logic start;
    logic end_init;
    logic calculated;
    logic hit_4;
    logic end_filling;
    logic end_traceB;
    logic we;
    logic en_init;
    logic en_read;
    logic en_ins;
    logic en_traceB;
    logic change_index;

    align_pkg::base_t [`SEQ_LEN-1:0] seq_a;
    align_pkg::base_t [`SEQ_LEN-1:0] seq_b;
    align_pkg::score_t               match_sc;
    align_pkg::score_t               mismatch_sc;
    align_pkg::score_t               gap_sc;

    logic [`ADDR_W-1:0] wr_addr;
    logic [`ADDR_W-1:0] fill_rd_addr;
    logic [`ADDR_W-1:0] trace_rd_addr;
    align_pkg::score_t  wr_score;
    align_pkg::score_t  fill_rd_score;
    align_pkg::score_t  trace_rd_score;
    align_pkg::dir_t    wr_dir;
    align_pkg::dir_t    trace_rd_dir;

    align_regs u_regs (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .done(done), .seq_a(seq_a), .seq_b(seq_b), .match_sc(match_sc),
        .mismatch_sc(mismatch_sc), .gap_sc(gap_sc), .start(start), .busy(busy)
    );

    align_ctrl u_ctrl (
        .clk(clk), .rst(rst), .start(start), .end_init(end_init),
        .calculated(calculated), .hit_4(hit_4), .end_filling(end_filling),
        .end_traceB(end_traceB), .we(we), .en_init(en_init), .en_read(en_read),
        .en_ins(en_ins), .en_traceB(en_traceB), .change_index(change_index)
    );

    fill_engine u_fill (
        .clk(clk), .rst(rst), .we(we), .en_init(en_init), .en_read(en_read),
        .en_ins(en_ins), .change_index(change_index), .seq_a(seq_a), .seq_b(seq_b),
        .match_sc(match_sc), .mismatch_sc(mismatch_sc), .gap_sc(gap_sc),
        .rd_score(fill_rd_score), .wr_addr(wr_addr), .wr_score(wr_score),
        .wr_dir(wr_dir), .rd_addr(fill_rd_addr), .end_init(end_init),
        .calculated(calculated), .hit_4(hit_4), .end_filling(end_filling)
    );

    traceback u_trace (
        .clk(clk), .rst(rst), .en_traceB(en_traceB), .rd_score(trace_rd_score),
        .rd_dir(trace_rd_dir), .seq_a(seq_a), .seq_b(seq_b), .rd_addr(trace_rd_addr),
        .op(op), .op_valid(op_valid), .score(score), .done(done),
        .end_traceB(end_traceB)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // score and direction matrices share the write address

    matrix_ram #(.T(align_pkg::score_t)) u_score_ram (
        .clk(clk), .wr_en(we), .wr_addr(wr_addr), .wr_data(wr_score),
        .rd_addr_a(fill_rd_addr), .rd_addr_b(trace_rd_addr),
        .rd_data_a(fill_rd_score), .rd_data_b(trace_rd_score)
    );

    matrix_ram #(.T(align_pkg::dir_t)) u_dir_ram (
        .clk(clk), .wr_en(we), .wr_addr(wr_addr), .wr_data(wr_dir),
        .rd_addr_a(fill_rd_addr), .rd_addr_b(trace_rd_addr),
        .rd_data_a(), .rd_data_b(trace_rd_dir)
    );

endmodule

`default_nettype wire

// File: logic/traceback.sv
`default_nettype none
`timescale 1ns/1ps

`include "align_consts.svh"

module traceback (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          en_traceB,
    input  wire align_pkg::score_t             rd_score,
    input  wire align_pkg::dir_t               rd_dir,
    input  wire align_pkg::base_t [`SEQ_LEN-1:0] seq_a,
    input  wire align_pkg::base_t [`SEQ_LEN-1:0] seq_b,
    output logic [`ADDR_W-1:0]                 rd_addr,
    output align_pkg::op_t                     op,
    output logic                               op_valid,
    output align_pkg::score_t                  score,
    output logic                               done,
    output logic                               end_traceB
);

    logic [`IDX_W-1:0] i;
    logic [`IDX_W-1:0] j;
    logic              phase;                // 0 address, 1 data back
    logic              at_origin;
    logic              at_corner;
    align_pkg::op_t    next_op;

    assign at_origin  = (i == '0) && (j == '0);
    assign at_corner  = (i == `IDX_W'(`SEQ_LEN)) && (j == `IDX_W'(`SEQ_LEN));
    assign end_traceB = en_traceB && at_origin;
    assign done       = end_traceB;
    assign rd_addr    = `ADDR_W'(i * `MAT_DIM + j);

    always_comb begin
        case (rd_dir)
            align_pkg::DIR_DIAG: begin
                next_op = (seq_a[i - 1'b1] == seq_b[j - 1'b1]) ?
                          align_pkg::OP_MATCH : align_pkg::OP_SUB;
            end
            align_pkg::DIR_UP: next_op = align_pkg::OP_DEL;
            default:           next_op = align_pkg::OP_INS;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            i        <= `IDX_W'(`SEQ_LEN);
            j        <= `IDX_W'(`SEQ_LEN);
            phase    <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            op_valid <= 1'b0;
            if (!en_traceB) begin
                i     <= `IDX_W'(`SEQ_LEN);  // park at the corner for the next run
                j     <= `IDX_W'(`SEQ_LEN);
                phase <= 1'b0;
            end else if (!at_origin) begin
                phase <= ~phase;
                if (phase) begin
                    op_valid <= 1'b1;
                    case (rd_dir)
                        align_pkg::DIR_DIAG: begin
                            i <= i - 1'b1;
                            j <= j - 1'b1;
                        end
                        align_pkg::DIR_UP:   i <= i - 1'b1;
                        align_pkg::DIR_LEFT: j <= j - 1'b1;
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_traceB && phase) begin
            op <= next_op;
            if (at_corner) begin
                score <= rd_score;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fill_engine.sv
`default_nettype none
`timescale 1ns/1ps

`include "align_consts.svh"

module fill_engine (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          we,
    input  wire logic                          en_init,
    input  wire logic                          en_read,
    input  wire logic                          en_ins,
    input  wire logic                          change_index,
    input  wire align_pkg::base_t [`SEQ_LEN-1:0] seq_a,
    input  wire align_pkg::base_t [`SEQ_LEN-1:0] seq_b,
    input  wire align_pkg::score_t             match_sc,
    input  wire align_pkg::score_t             mismatch_sc,
    input  wire align_pkg::score_t             gap_sc,
    input  wire align_pkg::score_t             rd_score,
    output logic [`ADDR_W-1:0]                 wr_addr,
    output align_pkg::score_t                  wr_score,
    output align_pkg::dir_t                    wr_dir,
    output logic [`ADDR_W-1:0]                 rd_addr,
    output logic                               end_init,
    output logic                               calculated,
    output logic                               hit_4,
    output logic                               end_filling
);

    logic [`BCNT_W-1:0] bcnt;
    logic [`IDX_W-1:0]  row;
    logic [`IDX_W-1:0]  gcol;
    logic [`IDX_W-1:0]  col;
    logic [`RCNT_W-1:0] rcnt;
    logic [`CCNT_W-1:0] ccnt;
    logic               reading;
    logic               last_group;
    logic               on_row0;
    logic [`IDX_W-1:0]  bidx;

    align_pkg::score_t window [`GROUP+1];  // row above, columns gcol-1 .. gcol+3
    align_pkg::score_t left;
    align_pkg::score_t diag_c;
    align_pkg::score_t up_c;
    align_pkg::score_t left_c;
    align_pkg::score_t best;
    align_pkg::dir_t   best_dir;

    assign reading    = en_read && !change_index;
    assign last_group = gcol == `IDX_W'(`SEQ_LEN - `GROUP + 1);
    assign col        = gcol + `IDX_W'(ccnt);

    assign end_init    = en_init && (bcnt == `BCNT_W'(2 * `SEQ_LEN));
    assign calculated  = reading && (rcnt == `RCNT_W'(`GROUP + 1));
    assign hit_4       = en_ins && (ccnt == `CCNT_W'(`GROUP - 1));
    assign end_filling = hit_4 && last_group && (row == `IDX_W'(`SEQ_LEN));

    // ~~~~~~~~~~~~~~~~~~~~
    // border cells, row 0 first and then column 0

    assign on_row0 = bcnt <= `BCNT_W'(`SEQ_LEN);
    assign bidx    = on_row0 ? `IDX_W'(bcnt) : `IDX_W'(bcnt - `BCNT_W'(`SEQ_LEN));

    // ~~~~~~~~~~~~~~~~~~~~
    // one inner cell per cycle

    assign diag_c = window[ccnt] + ((seq_a[row - 1'b1] == seq_b[col - 1'b1]) ?
                                    match_sc : mismatch_sc);
    assign up_c   = window[`RCNT_W'(ccnt) + 1'b1] + gap_sc;
    assign left_c = left + gap_sc;

    always_comb begin
        if (diag_c >= up_c && diag_c >= left_c) begin
            best     = diag_c;
            best_dir = align_pkg::DIR_DIAG;
        end else if (up_c >= left_c) begin
            best     = up_c;
            best_dir = align_pkg::DIR_UP;
        end else begin
            best     = left_c;
            best_dir = align_pkg::DIR_LEFT;
        end
    end

    always_comb begin
        if (en_init) begin
            wr_addr  = on_row0 ? `ADDR_W'(bidx) : `ADDR_W'(bidx * `MAT_DIM);
            wr_score = align_pkg::score_t'(bidx) * gap_sc;
            if (bcnt == '0) begin
                wr_dir = align_pkg::DIR_NONE;
            end else begin
                wr_dir = on_row0 ? align_pkg::DIR_LEFT : align_pkg::DIR_UP;
            end
        end else begin
            wr_addr  = `ADDR_W'(row * `MAT_DIM + col);
            wr_score = best;
            wr_dir   = best_dir;
        end
    end

    assign rd_addr = `ADDR_W'((row - 1'b1) * `MAT_DIM + gcol - 1'b1 + rcnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bcnt <= '0;
            row  <= `IDX_W'(1);
            gcol <= `IDX_W'(1);
            rcnt <= '0;
            ccnt <= '0;
        end else begin
            if (we && en_init) begin
                bcnt <= end_init ? '0 : bcnt + 1'b1;
                row  <= `IDX_W'(1);
                gcol <= `IDX_W'(1);
            end
            if (reading) begin
                rcnt <= calculated ? '0 : rcnt + 1'b1;
            end
            if (we && en_ins) begin
                ccnt <= ccnt + 1'b1;         // wraps to zero after the fourth cell
            end
            if (change_index) begin
                if (last_group) begin
                    gcol <= `IDX_W'(1);
                    row  <= row + 1'b1;
                end else begin
                    gcol <= gcol + `IDX_W'(`GROUP);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reading && rcnt != '0) begin
            window[rcnt - 1'b1] <= rd_score;
        end
        if (reading && rcnt == '0 && gcol == `IDX_W'(1)) begin
            left <= align_pkg::score_t'(row) * gap_sc;  // column 0 border of this row
        end
        if (we && en_ins) begin
            left <= best;
        end
    end

endmodule

`default_nettype wire

// File: logic/align_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module align_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic end_init,
    input  wire logic calculated,
    input  wire logic hit_4,
    input  wire logic end_filling,
    input  wire logic end_traceB,
    output logic      we,
    output logic      en_init,
    output logic      en_read,
    output logic      en_ins,
    output logic      en_traceB,
    output logic      change_index
);

    align_pkg::state_t state;
    align_pkg::state_t state_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= align_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            align_pkg::IDLE:    if (start) state_next = align_pkg::INIT;
            align_pkg::INIT:    if (end_init) state_next = align_pkg::READ;
            align_pkg::READ:    if (calculated) state_next = align_pkg::FILLING;
            align_pkg::CHANGE:  state_next = align_pkg::READ;
            align_pkg::FILLING: begin
                if (hit_4) begin
                    state_next = end_filling ? align_pkg::TRACE_B : align_pkg::CHANGE;
                end
            end
            align_pkg::TRACE_B: if (end_traceB) state_next = align_pkg::IDLE;
            default:            state_next = align_pkg::IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // enables decoded from the state alone

    always_comb begin
        we           = 1'b0;
        en_init      = 1'b0;
        en_read      = 1'b0;
        en_ins       = 1'b0;
        en_traceB    = 1'b0;
        change_index = 1'b0;
        case (state)
            align_pkg::INIT: begin
                we      = 1'b1;
                en_init = 1'b1;
            end
            align_pkg::READ: en_read = 1'b1;
            align_pkg::CHANGE: begin
                en_read      = 1'b1;         // the engine tells CHANGE apart by change_index
                change_index = 1'b1;
            end
            align_pkg::FILLING: begin
                we     = 1'b1;
                en_ins = 1'b1;
            end
            align_pkg::TRACE_B: en_traceB = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/align_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "align_consts.svh"

module align_regs (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          cfg_we,
    input  wire logic [`CFG_ADDR_W-1:0]        cfg_addr,
    input  wire logic [7:0]                    cfg_wdata,
    input  wire logic                          done,
    output align_pkg::base_t [`SEQ_LEN-1:0]    seq_a,
    output align_pkg::base_t [`SEQ_LEN-1:0]    seq_b,
    output align_pkg::score_t                  match_sc,
    output align_pkg::score_t                  mismatch_sc,
    output align_pkg::score_t                  gap_sc,
    output logic                               start,
    output logic                               busy
);

    logic              cfg_open;
    logic              start_wr;
    align_pkg::score_t wdata_sx;

    assign cfg_open = cfg_we && !busy;
    assign start_wr = cfg_open && (cfg_addr == `CFG_ADDR_W'(`REG_START));
    assign wdata_sx = align_pkg::score_t'(signed'(cfg_wdata));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start <= 1'b0;
            busy  <= 1'b0;
        end else begin
            start <= start_wr;               // single cycle pulse
            if (start_wr) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // the low three address bits select the base within either sequence
    always_ff @(posedge clk) begin
        if (cfg_open) begin
            if (cfg_addr < `CFG_ADDR_W'(`REG_SEQ_B)) begin
                seq_a[cfg_addr[2:0]] <= cfg_wdata[1:0];
            end else if (cfg_addr < `CFG_ADDR_W'(`REG_MATCH)) begin
                seq_b[cfg_addr[2:0]] <= cfg_wdata[1:0];
            end else if (cfg_addr == `CFG_ADDR_W'(`REG_MATCH)) begin
                match_sc <= wdata_sx;
            end else if (cfg_addr == `CFG_ADDR_W'(`REG_MISMATCH)) begin
                mismatch_sc <= wdata_sx;
            end else if (cfg_addr == `CFG_ADDR_W'(`REG_GAP)) begin
                gap_sc <= wdata_sx;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/matrix_ram.sv
`default_nettype none
`timescale 1ns/1ps

`include "align_consts.svh"

module matrix_ram #(
    parameter type T = align_pkg::score_t
) (
    input  wire logic                clk,
    input  wire logic                wr_en,
    input  wire logic [`ADDR_W-1:0]  wr_addr,
    input  wire T                    wr_data,
    input  wire logic [`ADDR_W-1:0]  rd_addr_a,
    input  wire logic [`ADDR_W-1:0]  rd_addr_b,
    output T                         rd_data_a,
    output T                         rd_data_b
);

    T mem [`MAT_ENTRIES];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data_a <= mem[rd_addr_a];     // data one cycle after the address
        rd_data_b <= mem[rd_addr_b];
    end

endmodule

`default_nettype wire

// File: logic/align_pkg.sv
`default_nettype none

package align_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // data types

    typedef logic [1:0] base_t;          // A=0, C=1, G=2, T=3

    typedef logic signed [9:0] score_t;

    typedef enum logic [1:0] {
        DIR_DIAG = 2'd0,
        DIR_UP   = 2'd1,
        DIR_LEFT = 2'd2,
        DIR_NONE = 2'd3                  // origin cell only
    } dir_t;

    typedef enum logic [1:0] {
        OP_MATCH = 2'd0,
        OP_SUB   = 2'd1,
        OP_INS   = 2'd2,                 // gap in sequence a
        OP_DEL   = 2'd3                  // gap in sequence b
    } op_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // controller states

    typedef enum logic [2:0] {
        IDLE    = 3'b000,
        INIT    = 3'b001,
        READ    = 3'b010,
        CHANGE  = 3'b011,
        FILLING = 3'b100,
        TRACE_B = 3'b101
    } state_t;

endpackage

`default_nettype wire

// File: logic/align_consts.svh
`ifndef ALIGN_CONSTS_SVH
`define ALIGN_CONSTS_SVH

`define SEQ_LEN     8
`define GROUP       4
`define MAT_DIM     (`SEQ_LEN + 1)
`define MAT_ENTRIES (`MAT_DIM * `MAT_DIM)
`define ADDR_W      7                    // holds MAT_ENTRIES = 81
`define IDX_W       4                    // row and column index, 0..SEQ_LEN
`define BCNT_W      5                    // border counter, 0..2*SEQ_LEN
`define RCNT_W      3                    // read counter, 0..GROUP+1
`define CCNT_W      2                    // cell counter within a group

// register map
`define CFG_ADDR_W   5
`define REG_SEQ_A    0
`define REG_SEQ_B    8
`define REG_MATCH    16
`define REG_MISMATCH 17
`define REG_GAP      18
`define REG_START    19

`endif
